// File: include/dcache_config.svh
/* geometry of the 2-way write-back data cache
   sets, ways and words per line must be powers of two */
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// core address and data word
`define DCACHE_ADDR_W 32
`define DCACHE_DATA_W 32

// organization
`define DCACHE_SETS 16
`define DCACHE_WAYS 2
`define DCACHE_LINE_WORDS 4

// byte within word, word within line
`define DCACHE_BYTE_W ($clog2(`DCACHE_DATA_W / 8))
`define DCACHE_WORD_W ($clog2(`DCACHE_LINE_WORDS))

// set index and tag split of the address
`define DCACHE_INDEX_W ($clog2(`DCACHE_SETS))
`define DCACHE_TAG_W (`DCACHE_ADDR_W - `DCACHE_INDEX_W - `DCACHE_WORD_W - `DCACHE_BYTE_W)

// one full line
`define DCACHE_LINE_W (`DCACHE_LINE_WORDS * `DCACHE_DATA_W)

`endif

// File: hw/dcache_pkg.sv
/* shared types of the data cache
   store data is right-aligned in wdata, reads return the whole aligned word */
`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

  // access size from the core
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } size_e;

  // control FSM states
  typedef enum logic [2:0] {
    ARMED,
    EVICT,
    FILL,
    RESPOND,
    FLUSH_SCAN,
    FLUSH_WRITE
  } ctrl_state_e;

  // line buffer commands, one cycle each
  typedef enum logic [1:0] {
    CMD_NOP,
    CMD_READ_LINE,
    CMD_WRITE_LINE
  } bus_cmd_e;

  // core request, held stable until ack
  typedef struct packed {
    logic                      valid;
    logic                      we;
    size_e                     size;
    logic [`DCACHE_ADDR_W-1:0] addr;
    logic [`DCACHE_DATA_W-1:0] wdata;
  } cpu_req_t;

  typedef struct packed {
    logic                      ack;
    logic [`DCACHE_DATA_W-1:0] rdata;
  } cpu_rsp_t;

  // burst request, addr is line aligned
  typedef struct packed {
    logic                      valid;
    logic                      we;
    logic [`DCACHE_ADDR_W-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic                      gnt;
    logic                      rvalid;
    logic                      wready;
    logic [`DCACHE_DATA_W-1:0] rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

// File: hw/dcache_ctrl.sv
/* control FSM of the data cache: lookup, eviction, fill, flush and acknowledge
   a hit is acked in its first cycle, a miss ends with one ack cycle in RESPOND */
`default_nettype none
`timescale 1ns/100ps

`include "dcache_config.svh"

module dcache_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  dcache_pkg::cpu_req_t    cpu_req_i,
  output logic                    ack_o,
  input  logic                    flush_i,
  output logic                    flush_rdy_o,
  input  logic                    hit_i,
  input  logic                    victim_dirty_i,
  input  logic                    any_dirty_i,
  input  logic                    bus_done_i,
  output dcache_pkg::bus_cmd_e    bus_cmd_o,
  output dcache_pkg::ctrl_state_e state_o,
  output logic                    tag_we_o,
  output logic                    clean_we_o,
  output logic                    fill_we_o,
  output logic                    store_we_o
);
  import dcache_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  bus_cmd_e    bus_cmd_q;
  bus_cmd_e    bus_cmd_d;
  logic        flush_pend_q;
  logic        flush_rdy_q;
  logic        lookup_hit;
  logic        flush_go;

  // hit on a live request in the lookup state
  assign lookup_hit = (state_q == ARMED) & cpu_req_i.valid & hit_i;
  assign flush_go   = flush_i | flush_pend_q;

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_d   = state_q;
    bus_cmd_d = CMD_NOP;
    case (state_q)
      ARMED: begin
        // a pending request goes first, the flush waits for an idle core
        if (cpu_req_i.valid && !hit_i) begin
          if (victim_dirty_i) begin
            state_d   = EVICT;
            bus_cmd_d = CMD_WRITE_LINE;
          end else begin
            state_d   = FILL;
            bus_cmd_d = CMD_READ_LINE;
          end
        end else if (!cpu_req_i.valid && flush_go) begin
          state_d = FLUSH_SCAN;
        end
      end
      EVICT: begin
        // victim is out, fetch the new line
        if (bus_done_i) begin
          state_d   = FILL;
          bus_cmd_d = CMD_READ_LINE;
        end
      end
      FILL: begin
        if (bus_done_i) begin
          state_d = RESPOND;
        end
      end
      RESPOND: begin
        state_d = ARMED;
      end
      FLUSH_SCAN: begin
        if (any_dirty_i) begin
          state_d   = FLUSH_WRITE;
          bus_cmd_d = CMD_WRITE_LINE;
        end else begin
          state_d = ARMED;
        end
      end
      FLUSH_WRITE: begin
        // dirty bit clears on this edge, rescan afterwards
        if (bus_done_i) begin
          state_d = FLUSH_SCAN;
        end
      end
      default: begin
        state_d = ARMED;
      end
    endcase
  end

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= ARMED;
      bus_cmd_q    <= CMD_NOP;
      flush_pend_q <= 1'b0;
      flush_rdy_q  <= 1'b1;
    end else begin
      state_q   <= state_d;
      bus_cmd_q <= bus_cmd_d;
      // keep the flush until the scan starts
      if (state_q == ARMED && state_d == FLUSH_SCAN) begin
        flush_pend_q <= 1'b0;
      end else if (flush_i) begin
        flush_pend_q <= 1'b1;
      end
      // ready drops right after the request, rises once nothing is dirty
      if (flush_i) begin
        flush_rdy_q <= 1'b0;
      end else if (state_q == FLUSH_SCAN && !any_dirty_i) begin
        flush_rdy_q <= 1'b1;
      end
    end
  end

  // write strobes, one cycle each
  assign store_we_o  = lookup_hit & cpu_req_i.we;
  assign tag_we_o    = (state_q == FILL) & bus_done_i;
  assign fill_we_o   = (state_q == FILL) & bus_done_i;
  assign clean_we_o  = (state_q == FLUSH_WRITE) & bus_done_i;

  assign ack_o       = lookup_hit | (state_q == RESPOND);
  assign flush_rdy_o = flush_rdy_q;
  assign bus_cmd_o   = bus_cmd_q;
  assign state_o     = state_q;

endmodule

`default_nettype wire

// File: hw/dcache_tag_store.sv
/* tags, valid and dirty flags per way and set, with hit compare and victim choice
   the victim is random, invalid ways are not preferred */
`default_nettype none
`timescale 1ns/100ps

`include "dcache_config.svh"

module dcache_tag_store (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic [`DCACHE_ADDR_W-1:0]        addr_i,
  input  dcache_pkg::ctrl_state_e          state_i,
  input  logic                             tag_we_i,
  input  logic                             clean_we_i,
  input  logic                             store_we_i,
  input  logic                             we_i,
  output logic                             hit_o,
  output logic [$clog2(`DCACHE_WAYS)-1:0]  hit_way_o,
  output logic [$clog2(`DCACHE_WAYS)-1:0]  victim_way_o,
  output logic                             victim_dirty_o,
  output logic [`DCACHE_TAG_W-1:0]         victim_tag_o,
  output logic                             any_dirty_o,
  output logic [`DCACHE_INDEX_W-1:0]       dirty_index_o,
  output logic [$clog2(`DCACHE_WAYS)-1:0]  dirty_way_o
);
  import dcache_pkg::*;

  localparam int unsigned WAY_W   = $clog2(`DCACHE_WAYS);
  localparam int unsigned INDEX_W = `DCACHE_INDEX_W;
  localparam int unsigned OFFS_W  = `DCACHE_BYTE_W + `DCACHE_WORD_W;
  // galois form of x^16 + x^14 + x^13 + x^11
  localparam logic [15:0] LFSR_TAPS = 16'hb400;
  localparam logic [15:0] LFSR_SEED = 16'hace1;

  logic [`DCACHE_TAG_W-1:0]                  tag_q [`DCACHE_WAYS][`DCACHE_SETS];
  logic [`DCACHE_WAYS-1:0][`DCACHE_SETS-1:0] valid_q;
  logic [`DCACHE_WAYS-1:0][`DCACHE_SETS-1:0] dirty_q;
  logic [15:0]                               lfsr_q;
  logic [15:0]                               lfsr_next;
  logic [INDEX_W-1:0]                        idx;
  logic [INDEX_W-1:0]                        sel_idx;
  logic [WAY_W-1:0]                          sel_way;
  logic [`DCACHE_TAG_W-1:0]                  req_tag;
  logic                                      flushing;

  assign idx      = addr_i[OFFS_W +: INDEX_W];
  assign req_tag  = addr_i[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
  assign flushing = (state_i == FLUSH_SCAN) | (state_i == FLUSH_WRITE);

  ////////////////////
  // lookup
  ////////////////////

  always_comb begin
    hit_o     = 1'b0;
    hit_way_o = '0;
    for (int w = 0; w < `DCACHE_WAYS; w++) begin
      if (valid_q[w][idx] && tag_q[w][idx] == req_tag) begin
        hit_o     = 1'b1;
        hit_way_o = WAY_W'(w);
      end
    end
  end

  // lowest dirty set and way, walked from the top so the last match wins
  always_comb begin
    any_dirty_o   = 1'b0;
    dirty_index_o = '0;
    dirty_way_o   = '0;
    for (int s = `DCACHE_SETS - 1; s >= 0; s--) begin
      for (int w = `DCACHE_WAYS - 1; w >= 0; w--) begin
        if (dirty_q[w][s]) begin
          any_dirty_o   = 1'b1;
          dirty_index_o = INDEX_W'(s);
          dirty_way_o   = WAY_W'(w);
        end
      end
    end
  end

  ////////////////////
  // victim choice
  ////////////////////

  assign lfsr_next = {1'b0, lfsr_q[15:1]} ^ (lfsr_q[0] ? LFSR_TAPS : 16'h0);

  // the lfsr steps on the edge that leaves ARMED, so the lookup already
  // uses the value that stays frozen through the miss
  assign victim_way_o = (state_i == ARMED) ? lfsr_next[WAY_W-1:0] : lfsr_q[WAY_W-1:0];

  // flush states look at the dirty line found by the search
  assign sel_idx        = flushing ? dirty_index_o : idx;
  assign sel_way        = flushing ? dirty_way_o : victim_way_o;
  assign victim_tag_o   = tag_q[sel_way][sel_idx];
  assign victim_dirty_o = valid_q[sel_way][sel_idx] & dirty_q[sel_way][sel_idx];

  ////////////////////
  // updates
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (tag_we_i) begin
      tag_q[victim_way_o][idx] <= req_tag;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      dirty_q <= '0;
      lfsr_q  <= LFSR_SEED;
    end else begin
      if (state_i == ARMED) begin
        lfsr_q <= lfsr_next;
      end
      // a filled line is dirty at once when the miss was a store
      if (tag_we_i) begin
        valid_q[victim_way_o][idx] <= 1'b1;
        dirty_q[victim_way_o][idx] <= we_i;
      end
      if (store_we_i) begin
        dirty_q[hit_way_o][idx] <= 1'b1;
      end
      // line went out during flush, valid stays set
      if (clean_we_i) begin
        dirty_q[dirty_way_o][dirty_index_o] <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/dcache_data_store.sv
/* line storage per set and way as a register array
   store data comes right-aligned and is moved to its byte lane here */
`default_nettype none
`timescale 1ns/100ps

`include "dcache_config.svh"

module dcache_data_store (
  input  logic                            clk_i,
  input  logic [`DCACHE_INDEX_W-1:0]      index_i,
  input  logic [$clog2(`DCACHE_WAYS)-1:0] way_i,
  input  dcache_pkg::cpu_req_t            req_i,
  input  logic [`DCACHE_LINE_W-1:0]       fill_line_i,
  input  logic                            fill_we_i,
  input  logic                            store_we_i,
  output logic [`DCACHE_LINE_W-1:0]       line_o,
  output logic [`DCACHE_DATA_W-1:0]       rdata_o
);
  import dcache_pkg::*;

  localparam int unsigned BYTES = `DCACHE_DATA_W / 8;

  logic [`DCACHE_LINE_W-1:0] line_q [`DCACHE_WAYS][`DCACHE_SETS];
  logic [`DCACHE_BYTE_W-1:0] byte_sel;
  logic [`DCACHE_WORD_W-1:0] word_sel;
  logic [BYTES-1:0]          be;
  logic [`DCACHE_DATA_W-1:0] lane_data;
  logic [`DCACHE_LINE_W-1:0] base_line;
  logic [`DCACHE_LINE_W-1:0] merged_line;

  assign byte_sel = req_i.addr[`DCACHE_BYTE_W-1:0];
  assign word_sel = req_i.addr[`DCACHE_BYTE_W +: `DCACHE_WORD_W];

  // byte enables from size and low address bits
  always_comb begin
    case (req_i.size)
      SIZE_BYTE: be = BYTES'(1) << byte_sel;
      SIZE_HALF: be = BYTES'(3) << byte_sel;
      default:   be = '1;
    endcase
  end

  assign lane_data = req_i.wdata << (8 * byte_sel);

  // write-allocate merges into the incoming line, a hit into the stored one
  assign base_line = fill_we_i ? fill_line_i : line_o;

  always_comb begin
    merged_line = base_line;
    for (int b = 0; b < BYTES; b++) begin
      if (be[b]) begin
        merged_line[(word_sel * BYTES + b) * 8 +: 8] = lane_data[b * 8 +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_we_i) begin
      line_q[way_i][index_i] <= req_i.we ? merged_line : fill_line_i;
    end else if (store_we_i) begin
      line_q[way_i][index_i] <= merged_line;
    end
  end

  // whole line feeds eviction, addressed word feeds the core
  assign line_o  = line_q[way_i][index_i];
  assign rdata_o = line_o[word_sel * `DCACHE_DATA_W +: `DCACHE_DATA_W];

endmodule

`default_nettype wire

// File: hw/dcache_line_buffer.sv
/* burst engine for line fill and write-back, one line in flight
   beats move only after the grant cycle, words go in order 0 to 3 */
`default_nettype none
`timescale 1ns/100ps

`include "dcache_config.svh"

module dcache_line_buffer (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  dcache_pkg::bus_cmd_e      bus_cmd_i,
  input  logic [`DCACHE_ADDR_W-1:0] line_addr_i,
  input  logic [`DCACHE_LINE_W-1:0] evict_line_i,
  output logic [`DCACHE_LINE_W-1:0] fill_line_o,
  output logic                      bus_done_o,
  output dcache_pkg::mem_req_t      mem_req_o,
  input  dcache_pkg::mem_rsp_t      mem_rsp_i,
  output logic [`DCACHE_DATA_W-1:0] mem_wdata_o
);
  import dcache_pkg::*;

  // address phase until grant
  logic                      req_q;
  // data phase until the last beat
  logic                      xfer_q;
  logic                      we_q;
  logic [`DCACHE_ADDR_W-1:0] addr_q;
  logic [`DCACHE_WORD_W-1:0] beat_q;
  logic [`DCACHE_LINE_W-1:0] buf_q;
  logic                      done_q;
  logic                      start;
  logic                      beat;
  logic                      last;

  assign start = (bus_cmd_i != CMD_NOP);
  // a write word is taken on wready, a read word arrives on rvalid
  assign beat  = xfer_q & (we_q ? mem_rsp_i.wready : mem_rsp_i.rvalid);
  assign last  = beat & (beat_q == '1);

  ////////////////////
  // sequencing
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q  <= 1'b0;
      xfer_q <= 1'b0;
      we_q   <= 1'b0;
      beat_q <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= last;
      if (start) begin
        req_q  <= 1'b1;
        we_q   <= (bus_cmd_i == CMD_WRITE_LINE);
        beat_q <= '0;
      end else if (req_q && mem_rsp_i.gnt) begin
        req_q  <= 1'b0;
        xfer_q <= 1'b1;
      end else if (beat) begin
        beat_q <= beat_q + 1'b1;
        if (last) begin
          xfer_q <= 1'b0;
        end
      end
    end
  end

  ////////////////////
  // line shifter
  ////////////////////

  // write words leave at the bottom, read words enter at the top,
  // so after four beats word 0 sits in the low bits either way
  always_ff @(posedge clk_i) begin
    if (start) begin
      addr_q <= line_addr_i;
      buf_q  <= (bus_cmd_i == CMD_WRITE_LINE) ? evict_line_i : '0;
    end else if (beat) begin
      buf_q <= {mem_rsp_i.rdata, buf_q[`DCACHE_LINE_W-1:`DCACHE_DATA_W]};
    end
  end

  assign mem_req_o   = '{valid: req_q, we: we_q, addr: addr_q};
  assign mem_wdata_o = buf_q[`DCACHE_DATA_W-1:0];
  assign fill_line_o = buf_q;
  assign bus_done_o  = done_q;

endmodule

`default_nettype wire

// File: hw/dcache_top.sv
/* 2-way write-back data cache with a burst memory port and a flush
   one physical address per request, no bus errors, 32-bit data only */
`default_nettype none
`timescale 1ns/100ps

`include "dcache_config.svh"

module dcache_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  dcache_pkg::cpu_req_t      cpu_req_i,
  output dcache_pkg::cpu_rsp_t      cpu_rsp_o,
  input  logic                      flush_i,
  output logic                      flush_rdy_o,
  output dcache_pkg::mem_req_t      mem_req_o,
  input  dcache_pkg::mem_rsp_t      mem_rsp_i,
  output logic [`DCACHE_DATA_W-1:0] mem_wdata_o
);
  import dcache_pkg::*;

  localparam int unsigned WAY_W  = $clog2(`DCACHE_WAYS);
  localparam int unsigned OFFS_W = `DCACHE_BYTE_W + `DCACHE_WORD_W;

  ctrl_state_e               state;
  bus_cmd_e                  bus_cmd;
  logic                      ack;
  logic                      hit;
  logic                      victim_dirty;
  logic                      any_dirty;
  logic                      bus_done;
  logic                      tag_we;
  logic                      clean_we;
  logic                      fill_we;
  logic                      store_we;
  logic                      flushing;
  logic [WAY_W-1:0]          hit_way;
  logic [WAY_W-1:0]          victim_way;
  logic [WAY_W-1:0]          dirty_way;
  logic [WAY_W-1:0]          data_way;
  logic [`DCACHE_TAG_W-1:0]  victim_tag;
  logic [`DCACHE_INDEX_W-1:0] dirty_index;
  logic [`DCACHE_INDEX_W-1:0] data_index;
  logic [`DCACHE_ADDR_W-1:0] line_addr;
  logic [`DCACHE_LINE_W-1:0] store_line;
  logic [`DCACHE_LINE_W-1:0] fill_line;
  logic [`DCACHE_DATA_W-1:0] rdata;

  ////////////////////
  // line selects
  ////////////////////

  assign flushing   = (state == FLUSH_SCAN) | (state == FLUSH_WRITE);
  assign data_index = flushing ? dirty_index : cpu_req_i.addr[OFFS_W +: `DCACHE_INDEX_W];
  // the hit way once the line is present, the victim while it is replaced
  assign data_way   = flushing ? dirty_way : (hit ? hit_way : victim_way);

  // fill reads the requested line, write-back sends the victim line
  assign line_addr = (state == FILL) ?
                     {cpu_req_i.addr[`DCACHE_ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}} :
                     {victim_tag, data_index, {OFFS_W{1'b0}}};

  assign cpu_rsp_o = '{ack: ack, rdata: rdata};

  dcache_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cpu_req_i      (cpu_req_i),
    .ack_o          (ack),
    .flush_i        (flush_i),
    .flush_rdy_o    (flush_rdy_o),
    .hit_i          (hit),
    .victim_dirty_i (victim_dirty),
    .any_dirty_i    (any_dirty),
    .bus_done_i     (bus_done),
    .bus_cmd_o      (bus_cmd),
    .state_o        (state),
    .tag_we_o       (tag_we),
    .clean_we_o     (clean_we),
    .fill_we_o      (fill_we),
    .store_we_o     (store_we)
  );

  dcache_tag_store u_tag_store (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .addr_i         (cpu_req_i.addr),
    .state_i        (state),
    .tag_we_i       (tag_we),
    .clean_we_i     (clean_we),
    .store_we_i     (store_we),
    .we_i           (cpu_req_i.we),
    .hit_o          (hit),
    .hit_way_o      (hit_way),
    .victim_way_o   (victim_way),
    .victim_dirty_o (victim_dirty),
    .victim_tag_o   (victim_tag),
    .any_dirty_o    (any_dirty),
    .dirty_index_o  (dirty_index),
    .dirty_way_o    (dirty_way)
  );

  dcache_data_store u_data_store (
    .clk_i       (clk_i),
    .index_i     (data_index),
    .way_i       (data_way),
    .req_i       (cpu_req_i),
    .fill_line_i (fill_line),
    .fill_we_i   (fill_we),
    .store_we_i  (store_we),
    .line_o      (store_line),
    .rdata_o     (rdata)
  );

  dcache_line_buffer u_line_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .bus_cmd_i    (bus_cmd),
    .line_addr_i  (line_addr),
    .evict_line_i (store_line),
    .fill_line_o  (fill_line),
    .bus_done_o   (bus_done),
    .mem_req_o    (mem_req_o),
    .mem_rsp_i    (mem_rsp_i),
    .mem_wdata_o  (mem_wdata_o)
  );

endmodule

`default_nettype wire

// File: test/dcache_mem_model.sv
/* burst memory for the cache testbench, the word array is open to hierarchical checks
   covers MEM_WORDS words from address 0, higher address bits are ignored */
`default_nettype none
`timescale 1ns/100ps

`include "dcache_config.svh"

module dcache_mem_model #(
  parameter int unsigned MEM_WORDS = 1024
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  dcache_pkg::mem_req_t      mem_req_i,
  output dcache_pkg::mem_rsp_t      mem_rsp_o,
  input  logic [`DCACHE_DATA_W-1:0] mem_wdata_i
);
  import dcache_pkg::*;

  localparam int unsigned IDX_W = $clog2(MEM_WORDS);

  logic [`DCACHE_DATA_W-1:0] mem [MEM_WORDS];
  logic                      busy_q;
  logic                      we_q;
  logic [IDX_W-1:0]          base_q;
  int unsigned               beat_q;
  int unsigned               wait_q;
  int unsigned               next_beat;
  logic                      gnt_q;
  logic                      rvalid_q;
  logic                      wready_q;
  logic [`DCACHE_DATA_W-1:0] rdata_q;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // each word holds its own byte address with a key on top
      for (int unsigned i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= (i * 4) ^ 32'h5a5a_0000;
      end
      busy_q   <= 1'b0;
      we_q     <= 1'b0;
      base_q   <= '0;
      beat_q   <= 0;
      wait_q   <= 2;
      gnt_q    <= 1'b0;
      rvalid_q <= 1'b0;
      wready_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      next_beat = beat_q;
      gnt_q    <= 1'b0;
      rvalid_q <= 1'b0;
      wready_q <= 1'b0;
      if (!busy_q) begin
        // address phase, grant after a random number of idle cycles
        if (mem_req_i.valid) begin
          if (wait_q == 0) begin
            gnt_q  <= 1'b1;
            busy_q <= 1'b1;
            we_q   <= mem_req_i.we;
            base_q <= mem_req_i.addr[2 +: IDX_W];
            beat_q <= 0;
            wait_q <= $urandom_range(3, 0);
          end else begin
            wait_q <= wait_q - 1;
          end
        end
      end else begin
        // beat offered in the last cycle is taken on this edge
        if (rvalid_q || wready_q) begin
          if (we_q) begin
            mem[base_q + IDX_W'(beat_q)] <= mem_wdata_i;
          end
          next_beat = beat_q + 1;
        end
        beat_q <= next_beat;
        if (next_beat == `DCACHE_LINE_WORDS) begin
          busy_q <= 1'b0;
        end else if ($urandom_range(3, 0) != 0) begin
          // a gap cycle keeps both strobes low
          rvalid_q <= !we_q;
          wready_q <= we_q;
          rdata_q  <= mem[base_q + IDX_W'(next_beat)];
        end
      end
    end
  end

  assign mem_rsp_o = '{gnt: gnt_q, rvalid: rvalid_q, wready: wready_q, rdata: rdata_q};

endmodule

`default_nettype wire

// File: test/dcache_tb.sv
/* testbench for the data cache, a table of core operations against a burst memory model
   all table addresses stay below 4 KB, the span of the memory model */
`default_nettype none
`timescale 1ns/100ps

`include "dcache_config.svh"

module dcache_tb;
  import dcache_pkg::*;

  localparam int unsigned CLK_HALF   = 20;
  localparam int unsigned DRIVE_DLY  = 2;
  localparam int unsigned RST_CYCLES = 16;
  localparam int unsigned NUM_ROWS   = 22;
  localparam int unsigned ROW_CYCLES = 200;
  localparam logic [31:0] FILL_KEY   = 32'h5a5a_0000;

  typedef enum logic [1:0] {
    OP_READ,
    OP_WRITE,
    OP_FLUSH
  } op_e;

  // one table row, hit means the ack must come in the lookup cycle
  typedef struct packed {
    op_e         op;
    logic [31:0] addr;
    size_e       size;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        hit;
  } row_t;

  logic        clk;
  logic        rst_n;
  logic        flush;
  logic        flush_rdy;
  logic [31:0] mem_wdata;
  cpu_req_t    cpu_req;
  cpu_rsp_t    cpu_rsp;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;
  row_t        rows [NUM_ROWS];
  // expected memory words, keyed by word address
  logic [31:0] shadow [logic [31:0]];
  int unsigned n_checks;
  int unsigned rd_errs;
  int unsigned hit_errs;
  int unsigned mem_errs;
  int unsigned flow_errs;

  dcache_top dut0 (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .cpu_req_i   (cpu_req),
    .cpu_rsp_o   (cpu_rsp),
    .flush_i     (flush),
    .flush_rdy_o (flush_rdy),
    .mem_req_o   (mem_req),
    .mem_rsp_i   (mem_rsp),
    .mem_wdata_o (mem_wdata)
  );

  dcache_mem_model mem0 (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .mem_req_i   (mem_req),
    .mem_rsp_o   (mem_rsp),
    .mem_wdata_i (mem_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_HALF) clk = ~clk;
  end

  ////////////////////
  // reference
  ////////////////////

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ FILL_KEY;
  endfunction

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    logic [31:0] key;
    key = {addr[31:2], 2'b00};
    return shadow.exists(key) ? shadow[key] : fill_word(addr);
  endfunction

  // little-endian byte lanes, wdata is right-aligned
  task automatic record_store(input logic [31:0] addr, input size_e size,
                              input logic [31:0] wdata);
    logic [31:0] word;
    int          nbytes;
    word   = expected_word(addr);
    nbytes = (size == SIZE_BYTE) ? 1 : ((size == SIZE_HALF) ? 2 : 4);
    for (int b = 0; b < nbytes; b++) begin
      word[(int'(addr[1:0]) + b) * 8 +: 8] = wdata[b * 8 +: 8];
    end
    shadow[{addr[31:2], 2'b00}] = word;
  endtask

  ////////////////////
  // table
  ////////////////////

  task automatic load_table();
    // one line, then byte and halfword merge
    rows[0]  = '{OP_READ,  32'h0000_0040, SIZE_WORD, 32'h0000_0000, 32'h5a5a_0040, 1'b0};
    rows[1]  = '{OP_READ,  32'h0000_0048, SIZE_WORD, 32'h0000_0000, 32'h5a5a_0048, 1'b1};
    rows[2]  = '{OP_WRITE, 32'h0000_0041, SIZE_BYTE, 32'h0000_00a5, 32'h0000_0000, 1'b1};
    rows[3]  = '{OP_WRITE, 32'h0000_0042, SIZE_HALF, 32'h0000_1234, 32'h0000_0000, 1'b1};
    rows[4]  = '{OP_READ,  32'h0000_0040, SIZE_WORD, 32'h0000_0000, 32'h1234_a540, 1'b1};
    rows[5]  = '{OP_READ,  32'h0000_0049, SIZE_BYTE, 32'h0000_0000, 32'h5a5a_0048, 1'b1};
    // three lines in set 2 force a dirty eviction
    rows[6]  = '{OP_WRITE, 32'h0000_0120, SIZE_WORD, 32'hdead_0120, 32'h0000_0000, 1'b0};
    rows[7]  = '{OP_WRITE, 32'h0000_0224, SIZE_WORD, 32'hbeef_0224, 32'h0000_0000, 1'b0};
    rows[8]  = '{OP_WRITE, 32'h0000_0328, SIZE_WORD, 32'hcafe_0328, 32'h0000_0000, 1'b0};
    rows[9]  = '{OP_READ,  32'h0000_0120, SIZE_WORD, 32'h0000_0000, 32'hdead_0120, 1'b0};
    rows[10] = '{OP_READ,  32'h0000_0224, SIZE_WORD, 32'h0000_0000, 32'hbeef_0224, 1'b0};
    rows[11] = '{OP_READ,  32'h0000_0328, SIZE_WORD, 32'h0000_0000, 32'hcafe_0328, 1'b0};
    rows[12] = '{OP_READ,  32'h0000_0124, SIZE_WORD, 32'h0000_0000, 32'h5a5a_0124, 1'b0};
    // more dirty lines, then flush
    rows[13] = '{OP_WRITE, 32'h0000_0382, SIZE_HALF, 32'h0000_beef, 32'h0000_0000, 1'b0};
    rows[14] = '{OP_WRITE, 32'h0000_005c, SIZE_WORD, 32'h0bad_f00d, 32'h0000_0000, 1'b0};
    rows[15] = '{OP_FLUSH, 32'h0000_0000, SIZE_WORD, 32'h0000_0000, 32'h0000_0000, 1'b0};
    // lines alone in their set stay valid across the flush
    rows[16] = '{OP_READ,  32'h0000_0040, SIZE_WORD, 32'h0000_0000, 32'h1234_a540, 1'b1};
    rows[17] = '{OP_READ,  32'h0000_0380, SIZE_WORD, 32'h0000_0000, 32'hbeef_0380, 1'b1};
    rows[18] = '{OP_READ,  32'h0000_005c, SIZE_WORD, 32'h0000_0000, 32'h0bad_f00d, 1'b1};
    rows[19] = '{OP_READ,  32'h0000_0044, SIZE_WORD, 32'h0000_0000, 32'h5a5a_0044, 1'b1};
    rows[20] = '{OP_READ,  32'h0000_0328, SIZE_WORD, 32'h0000_0000, 32'hcafe_0328, 1'b0};
    rows[21] = '{OP_FLUSH, 32'h0000_0000, SIZE_WORD, 32'h0000_0000, 32'h0000_0000, 1'b0};
  endtask

  ////////////////////
  // operations
  ////////////////////

  // entered 2 ns after an edge, leaves 2 ns after the edge that follows the ack
  task automatic run_access(input int i);
    row_t        r;
    int unsigned waited;
    r      = rows[i];
    waited = 0;
    cpu_req = '{valid: 1'b1, we: (r.op == OP_WRITE), size: r.size, addr: r.addr,
                wdata: r.wdata};
    @(negedge clk);
    while (!cpu_rsp.ack) begin
      waited++;
      @(negedge clk);
    end
    if (r.op == OP_READ) begin
      n_checks++;
      assert (cpu_rsp.rdata == r.rdata) else begin
        $display("Error: row %0d cpu_rsp_o.rdata = %h, expected %h (addr %h)",
                 i, cpu_rsp.rdata, r.rdata, r.addr);
        rd_errs++;
      end
    end else begin
      record_store(r.addr, r.size, r.wdata);
    end
    n_checks++;
    assert (!r.hit || waited == 0) else begin
      $display("row %0d: access to %h missed, ack came %0d cycles late", i, r.addr, waited);
      hit_errs++;
    end
    @(posedge clk);
    #(DRIVE_DLY);
    cpu_req = '0;
  endtask

  // every stored word must have reached the memory array
  task automatic check_memory(input int i);
    logic [31:0] word_addr;
    foreach (shadow[a]) begin
      word_addr = a;
      n_checks++;
      assert (mem0.mem[word_addr[11:2]] == shadow[a]) else begin
        $display("Error: row %0d mem0.mem[%h] = %h, expected %h",
                 i, word_addr, mem0.mem[word_addr[11:2]], shadow[a]);
        mem_errs++;
      end
    end
  endtask

  task automatic run_flush(input int i);
    flush = 1'b1;
    @(posedge clk);
    #(DRIVE_DLY);
    flush = 1'b0;
    @(negedge clk);
    n_checks++;
    assert (!flush_rdy) else begin
      $display("Error: row %0d flush_rdy_o = %h, expected %h", i, flush_rdy, 1'b0);
      flow_errs++;
    end
    while (!flush_rdy) begin
      @(negedge clk);
    end
    check_memory(i);
  endtask

  task automatic close_run();
    int unsigned total;
    total = rd_errs + hit_errs + mem_errs + flow_errs;
    $display("checks %0d, errors %0d (read data %0d, hit %0d, memory %0d, handshake %0d)",
             n_checks, total, rd_errs, hit_errs, mem_errs, flow_errs);
    if (total == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    void'($urandom(32'h61a1));
    cpu_req   = '0;
    flush     = 1'b0;
    rst_n     = 1'b0;
    n_checks  = 0;
    rd_errs   = 0;
    hit_errs  = 0;
    mem_errs  = 0;
    flow_errs = 0;
    load_table();
    repeat (RST_CYCLES) @(posedge clk);
    #(DRIVE_DLY);
    rst_n = 1'b1;
    // idle outputs straight after reset
    @(negedge clk);
    n_checks += 3;
    assert (!cpu_rsp.ack) else begin
      $display("Error: cpu_rsp_o.ack = %h, expected %h", cpu_rsp.ack, 1'b0);
      flow_errs++;
    end
    assert (!mem_req.valid) else begin
      $display("Error: mem_req_o.valid = %h, expected %h", mem_req.valid, 1'b0);
      flow_errs++;
    end
    assert (flush_rdy) else begin
      $display("Error: flush_rdy_o = %h, expected %h", flush_rdy, 1'b1);
      flow_errs++;
    end
    for (int i = 0; i < NUM_ROWS; i++) begin
      @(posedge clk);
      #(DRIVE_DLY);
      if (rows[i].op == OP_FLUSH) begin
        run_flush(i);
      end else begin
        run_access(i);
      end
    end
    close_run();
  end

  // watchdog, a generous budget per table row
  initial begin
    repeat (RST_CYCLES + NUM_ROWS * ROW_CYCLES) @(posedge clk);
    $display("timeout: the table did not complete within %0d cycles",
             RST_CYCLES + NUM_ROWS * ROW_CYCLES);
    flow_errs++;
    close_run();
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
hw/dcache_pkg.sv
hw/dcache_ctrl.sv
hw/dcache_tag_store.sv
hw/dcache_data_store.sv
hw/dcache_line_buffer.sv
hw/dcache_top.sv
test/dcache_mem_model.sv
test/dcache_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sources.f --top-module dcache_tb -Mdir obj_dir; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/Vdcache_tb)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the verdict comes from the testbench output
if printf '%s\n' "$out" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1
